/* verilog/fifo_settings.svh */
`ifndef FIFO_SETTINGS_SVH
`define FIFO_SETTINGS_SVH

////////////////////////////////////////////////////////////////////////
// Geometry of the dual-clock FIFO.
////////////////////////////////////////////////////////////////////////

`define FIFO_DATA_WIDTH 8    // Bits per stored word.
`define FIFO_DEPTH      16   // Entries, a power of two.
`define FIFO_ADDR_WIDTH 4    // log2 of the depth.

// Flag thresholds, in words of occupancy.
`define FIFO_AFULL      14   // Almost-full at or above this count.
`define FIFO_AEMPTY     2    // Almost-empty at or below this count.

`endif

/* verilog/fifo_pkg.sv */
package fifo_pkg;
  `include "fifo_settings.svh"

  typedef logic [`FIFO_DATA_WIDTH-1:0] fifo_data_t;
  typedef logic [`FIFO_ADDR_WIDTH-1:0] fifo_addr_t;
  typedef logic [`FIFO_ADDR_WIDTH:0]   fifo_ptr_t;  // Address plus the wrap bit.

  // Gray to binary, each bit is the XOR of all gray bits above and at it.
  function automatic fifo_ptr_t gray_to_bin(input fifo_ptr_t gray);
    fifo_ptr_t bin;
    bin[`FIFO_ADDR_WIDTH] = gray[`FIFO_ADDR_WIDTH];
    for (int i = `FIFO_ADDR_WIDTH - 1; i >= 0; i--) begin
      bin[i] = bin[i+1] ^ gray[i];
    end
    return bin;
  endfunction

  function automatic fifo_ptr_t bin_to_gray(input fifo_ptr_t bin);
    return (bin >> 1) ^ bin;
  endfunction
endpackage

/* verilog/rst_sync.sv */
`timescale 1ns/10ps

module rst_sync (
  input  logic clk,
  input  logic arst_n,
  output logic rst_sync_n
);

  logic meta_n;  // First stage, may go metastable on release.

  // Assertion is immediate, release waits two edges of clk.
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      meta_n     <= 1'b0;
      rst_sync_n <= 1'b0;
    end else begin
      meta_n     <= 1'b1;
      rst_sync_n <= meta_n;
    end
  end

endmodule

/* verilog/ptr_sync.sv */
`timescale 1ns/10ps

module ptr_sync import fifo_pkg::*; (
  input  logic      clk,
  input  logic      rst_n,
  input  fifo_ptr_t ptr_gray,
  output fifo_ptr_t ptr_gray_sync
);

  fifo_ptr_t ptr_gray_meta;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      ptr_gray_meta <= '0;
      ptr_gray_sync <= '0;
    end else begin
      ptr_gray_meta <= ptr_gray;       // Captures the other domain.
      ptr_gray_sync <= ptr_gray_meta;
    end
  end

  // The source side may step several times between two edges of clk, so
  // the check runs on every change of the source pointer instead.
  a_gray_one_bit_step: assert property (
    @(ptr_gray) disable iff (!rst_n)
      !$isunknown($past(ptr_gray)) |-> $countones(ptr_gray ^ $past(ptr_gray)) <= 1
  ) else $error("gray pointer moved by more than one bit");

endmodule

/* verilog/dualport_ram_async.sv */
`timescale 1ns/10ps
`include "fifo_settings.svh"

module dualport_ram_async import fifo_pkg::*; (
  input  logic       wr_clk,
  input  logic       wr_en,
  input  fifo_addr_t wr_addr,
  input  fifo_data_t wr_data,
  input  logic       rd_clk,
  input  logic       rd_rst_n,
  input  logic       rd_en,
  input  fifo_addr_t rd_addr,
  output fifo_data_t rd_data
);

  fifo_data_t mem [`FIFO_DEPTH];

  ////////////////////////////////////////////////////////////////////////
  // Write port
  ////////////////////////////////////////////////////////////////////////

  always_ff @(posedge wr_clk) begin
    if (wr_en) begin
      mem[wr_addr] <= wr_data;
    end
  end

  ////////////////////////////////////////////////////////////////////////
  // Read port
  ////////////////////////////////////////////////////////////////////////

  // The word stays on rd_data until the next accepted read.
  always_ff @(posedge rd_clk or negedge rd_rst_n) begin
    if (!rd_rst_n) begin
      rd_data <= '0;
    end else if (rd_en) begin
      rd_data <= mem[rd_addr];
    end
  end

endmodule

/* verilog/fifo_wr_ptr.sv */
`timescale 1ns/10ps
`include "fifo_settings.svh"

module fifo_wr_ptr import fifo_pkg::*; (
  input  logic       wr_clk,
  input  logic       wr_rst_n,
  input  logic       wr_en,
  input  fifo_ptr_t  rd_ptr_gray_sync,
  output logic       mem_wr_en,
  output fifo_addr_t mem_wr_addr,
  output fifo_ptr_t  wr_ptr_gray,
  output logic       full,
  output logic       afull
);

  localparam int AW = `FIFO_ADDR_WIDTH;

  fifo_ptr_t wr_ptr;
  fifo_ptr_t wr_ptr_nxt;
  fifo_ptr_t wr_ptr_gray_nxt;
  fifo_ptr_t rd_ptr_bin;
  fifo_ptr_t used_nxt;
  logic      wr_vld;
  logic      full_nxt;
  logic      afull_nxt;

  ////////////////////////////////////////////////////////////////////////
  // Write pointer
  ////////////////////////////////////////////////////////////////////////

  assign wr_vld          = wr_en && !full;  // Writes while full are dropped.
  assign wr_ptr_nxt      = wr_vld ? wr_ptr + 1'b1 : wr_ptr;
  assign wr_ptr_gray_nxt = bin_to_gray(wr_ptr_nxt);

  always_ff @(posedge wr_clk or negedge wr_rst_n) begin
    if (!wr_rst_n) begin
      wr_ptr      <= '0;
      wr_ptr_gray <= '0;
    end else begin
      wr_ptr      <= wr_ptr_nxt;
      wr_ptr_gray <= wr_ptr_gray_nxt;
    end
  end

  assign mem_wr_en   = wr_vld;
  assign mem_wr_addr = wr_ptr[AW-1:0];

  ////////////////////////////////////////////////////////////////////////
  // Flags
  ////////////////////////////////////////////////////////////////////////

  // Full when the writer is one whole lap ahead: wrap bit and the bit
  // below it differ in gray code, the rest match.
  assign full_nxt = (wr_ptr_gray_nxt ==
                     {~rd_ptr_gray_sync[AW:AW-1], rd_ptr_gray_sync[AW-2:0]});

  assign rd_ptr_bin = gray_to_bin(rd_ptr_gray_sync);
  assign used_nxt   = wr_ptr_nxt - rd_ptr_bin;
  assign afull_nxt  = (used_nxt >= fifo_ptr_t'(`FIFO_AFULL));

  always_ff @(posedge wr_clk or negedge wr_rst_n) begin
    if (!wr_rst_n) begin
      full  <= 1'b0;
      afull <= 1'b0;
    end else begin
      full  <= full_nxt;
      afull <= afull_nxt;
    end
  end

  // The synchronized read pointer only lags, so an accepted write must
  // always find room by the writer's own count as well.
  a_no_write_when_full: assert property (
    @(posedge wr_clk) disable iff (!wr_rst_n)
      mem_wr_en |-> !full && ((wr_ptr - rd_ptr_bin) < fifo_ptr_t'(`FIFO_DEPTH))
  ) else $error("write accepted with no free entry");

endmodule

/* verilog/fifo_rd_ptr.sv */
`timescale 1ns/10ps
`include "fifo_settings.svh"

module fifo_rd_ptr import fifo_pkg::*; (
  input  logic       rd_clk,
  input  logic       rd_rst_n,
  input  logic       rd_en,
  input  fifo_ptr_t  wr_ptr_gray_sync,
  output logic       mem_rd_en,
  output fifo_addr_t mem_rd_addr,
  output fifo_ptr_t  rd_ptr_gray,
  output logic       empty,
  output logic       aempty
);

  localparam int AW = `FIFO_ADDR_WIDTH;

  fifo_ptr_t rd_ptr;
  fifo_ptr_t rd_ptr_nxt;
  fifo_ptr_t rd_ptr_gray_nxt;
  fifo_ptr_t wr_ptr_bin;
  fifo_ptr_t used_nxt;
  logic      rd_vld;
  logic      empty_nxt;
  logic      aempty_nxt;

  ////////////////////////////////////////////////////////////////////////
  // Read pointer
  ////////////////////////////////////////////////////////////////////////

  assign rd_vld          = rd_en && !empty;  // Reads while empty are ignored.
  assign rd_ptr_nxt      = rd_vld ? rd_ptr + 1'b1 : rd_ptr;
  assign rd_ptr_gray_nxt = bin_to_gray(rd_ptr_nxt);

  always_ff @(posedge rd_clk or negedge rd_rst_n) begin
    if (!rd_rst_n) begin
      rd_ptr      <= '0;
      rd_ptr_gray <= '0;
    end else begin
      rd_ptr      <= rd_ptr_nxt;
      rd_ptr_gray <= rd_ptr_gray_nxt;
    end
  end

  assign mem_rd_en   = rd_vld;
  assign mem_rd_addr = rd_ptr[AW-1:0];

  ////////////////////////////////////////////////////////////////////////
  // Flags
  ////////////////////////////////////////////////////////////////////////

  assign empty_nxt = (rd_ptr_gray_nxt == wr_ptr_gray_sync);

  assign wr_ptr_bin = gray_to_bin(wr_ptr_gray_sync);
  assign used_nxt   = wr_ptr_bin - rd_ptr_nxt;
  assign aempty_nxt = (used_nxt <= fifo_ptr_t'(`FIFO_AEMPTY));

  // Both flags come out of reset set, the FIFO holds nothing.
  always_ff @(posedge rd_clk or negedge rd_rst_n) begin
    if (!rd_rst_n) begin
      empty  <= 1'b1;
      aempty <= 1'b1;
    end else begin
      empty  <= empty_nxt;
      aempty <= aempty_nxt;
    end
  end

  // An accepted read must find at least one word by the reader's own
  // count of the synchronized write pointer.
  a_no_read_when_empty: assert property (
    @(posedge rd_clk) disable iff (!rd_rst_n)
      mem_rd_en |-> !empty && (wr_ptr_bin != rd_ptr)
  ) else $error("read accepted from an empty FIFO");

endmodule

/* verilog/async_fifo.sv */
`timescale 1ns/10ps

module async_fifo import fifo_pkg::*; (
  input  logic       wr_clk,
  input  logic       wr_rst_n,
  input  logic       wr_en,
  input  fifo_data_t wr_data,
  input  logic       rd_clk,
  input  logic       rd_en,
  output fifo_data_t rd_data,
  output logic       full,
  output logic       afull,
  output logic       empty,
  output logic       aempty
);

  logic       wr_rst_sync_n;
  logic       rd_rst_sync_n;
  logic       mem_wr_en;
  fifo_addr_t mem_wr_addr;
  logic       mem_rd_en;
  fifo_addr_t mem_rd_addr;
  fifo_ptr_t  wr_ptr_gray;
  fifo_ptr_t  wr_ptr_gray_sync;  // Write pointer seen on rd_clk.
  fifo_ptr_t  rd_ptr_gray;
  fifo_ptr_t  rd_ptr_gray_sync;  // Read pointer seen on wr_clk.

  ////////////////////////////////////////////////////////////////////////
  // Reset release, one synchronizer per clock domain
  ////////////////////////////////////////////////////////////////////////

  rst_sync u_wr_rst_sync (
    .clk        (wr_clk),
    .arst_n     (wr_rst_n),
    .rst_sync_n (wr_rst_sync_n)
  );

  rst_sync u_rd_rst_sync (
    .clk        (rd_clk),
    .arst_n     (wr_rst_n),
    .rst_sync_n (rd_rst_sync_n)
  );

  ////////////////////////////////////////////////////////////////////////
  // Producer and consumer
  ////////////////////////////////////////////////////////////////////////

  fifo_wr_ptr u_wr_ptr (
    .wr_clk           (wr_clk),
    .wr_rst_n         (wr_rst_sync_n),
    .wr_en            (wr_en),
    .rd_ptr_gray_sync (rd_ptr_gray_sync),
    .mem_wr_en        (mem_wr_en),
    .mem_wr_addr      (mem_wr_addr),
    .wr_ptr_gray      (wr_ptr_gray),
    .full             (full),
    .afull            (afull)
  );

  fifo_rd_ptr u_rd_ptr (
    .rd_clk           (rd_clk),
    .rd_rst_n         (rd_rst_sync_n),
    .rd_en            (rd_en),
    .wr_ptr_gray_sync (wr_ptr_gray_sync),
    .mem_rd_en        (mem_rd_en),
    .mem_rd_addr      (mem_rd_addr),
    .rd_ptr_gray      (rd_ptr_gray),
    .empty            (empty),
    .aempty           (aempty)
  );

  ////////////////////////////////////////////////////////////////////////
  // Pointer crossings
  ////////////////////////////////////////////////////////////////////////

  ptr_sync u_wr2rd_sync (
    .clk           (rd_clk),
    .rst_n         (rd_rst_sync_n),
    .ptr_gray      (wr_ptr_gray),
    .ptr_gray_sync (wr_ptr_gray_sync)
  );

  ptr_sync u_rd2wr_sync (
    .clk           (wr_clk),
    .rst_n         (wr_rst_sync_n),
    .ptr_gray      (rd_ptr_gray),
    .ptr_gray_sync (rd_ptr_gray_sync)
  );

  // Storage.
  dualport_ram_async u_ram (
    .wr_clk   (wr_clk),
    .wr_en    (mem_wr_en),
    .wr_addr  (mem_wr_addr),
    .wr_data  (wr_data),
    .rd_clk   (rd_clk),
    .rd_rst_n (rd_rst_sync_n),
    .rd_en    (mem_rd_en),
    .rd_addr  (mem_rd_addr),
    .rd_data  (rd_data)
  );

endmodule

/* tb/async_fifo_tb.sv */
`timescale 1ns/10ps
`include "fifo_settings.svh"

module async_fifo_tb;

  typedef logic [`FIFO_DATA_WIDTH-1:0] word_t;

  localparam logic [31:0] SEED  = 32'h14af9e0a;
  localparam int          WORDS = 200;  // Words pushed through in the streaming test.

  logic  wr_clk = 1'b0;
  logic  rd_clk = 1'b0;
  logic  wr_rst_n;
  logic  wr_en;
  word_t wr_data;
  logic  rd_en;
  word_t rd_data;
  logic  full;
  logic  afull;
  logic  empty;
  logic  aempty;

  word_t       model_q[$];  // Accepted words not yet read.
  logic [31:0] seed_state = SEED;
  int          errors = 0;
  int          tests_run = 0;
  int          tests_failed = 0;

  always #2 rd_clk = ~rd_clk;
  always #3 wr_clk = ~wr_clk;

  async_fifo dut_i (.*);

  //////////////////////////////////////////////////////////////////////
  // Helpers
  //////////////////////////////////////////////////////////////////////

  function automatic logic [31:0] lcg_next(input logic [31:0] s);
    return s * 32'd1664525 + 32'd1013904223;
  endfunction

  task automatic check_val(input string name, input logic [31:0] exp, input logic [31:0] act);
    if (exp !== act) begin
      $display("ERROR %s: expected %0h, actual %0h", name, exp, act);
      errors++;
    end
  endtask

  task automatic wait_empty(input logic level, input string name);
    for (int cycles = 0; cycles < 50; cycles++) begin
      if (empty === level) return;
      @(posedge rd_clk);
    end
    $display("%s: empty never went to %0b", name, level);
    errors++;
  endtask

  // Flag values read right after an edge are the ones the DUT used at it.
  task automatic write_word(input word_t d, output logic accepted);
    @(posedge wr_clk);
    wr_en   <= 1'b1;
    wr_data <= d;
    @(posedge wr_clk);
    accepted = !full;
    wr_en   <= 1'b0;
  endtask

  task automatic read_word(output logic accepted, output word_t d);
    @(posedge rd_clk);
    rd_en <= 1'b1;
    @(posedge rd_clk);
    accepted = !empty;
    rd_en    <= 1'b0;
    @(posedge rd_clk);
    d = rd_data;  // Loaded on the edge that accepted the read.
  endtask

  task automatic end_test(input string name, input int errors_before);
    tests_run++;
    if (errors == errors_before) begin
      $display("%s: passed", name);
    end else begin
      tests_failed++;
      $display("%s: failed", name);
    end
  endtask

  //////////////////////////////////////////////////////////////////////
  // Tests
  //////////////////////////////////////////////////////////////////////

  task automatic test_reset();
    int e0;
    e0 = errors;
    check_val("reset_values", 1, empty);
    check_val("reset_values", 1, aempty);
    check_val("reset_values", 0, full);
    check_val("reset_values", 0, afull);
    end_test("reset_values", e0);
  endtask

  task automatic test_single();
    int    e0;
    logic  acc;
    word_t d;
    e0 = errors;
    write_word(8'h5a, acc);
    check_val("single_word", 1, acc);
    wait_empty(1'b0, "single_word");
    read_word(acc, d);
    check_val("single_word", 1, acc);
    check_val("single_word", 8'h5a, d);
    wait_empty(1'b1, "single_word");
    end_test("single_word", e0);
  endtask

  task automatic test_fill();
    int   e0;
    int   n;
    logic acc;
    e0  = errors;
    n   = 0;
    acc = 1'b1;
    repeat (4) @(posedge wr_clk);  // Last read pointer reaches the writer.
    for (int i = 0; i < `FIFO_DEPTH + 2 && acc; i++) begin
      seed_state = lcg_next(seed_state);
      write_word(seed_state[23:16], acc);
      if (acc) begin
        model_q.push_back(seed_state[23:16]);
        n++;
      end
      if (acc && n == `FIFO_AFULL) begin
        @(posedge wr_clk);
        check_val("fill_overflow", 1, afull);
        check_val("fill_overflow", 0, full);
      end
    end
    check_val("fill_overflow", `FIFO_DEPTH, n);  // The last attempt hit full and was dropped.
    check_val("fill_overflow", 1, full);
    end_test("fill_overflow", e0);
  endtask

  task automatic test_drain();
    int    e0;
    logic  acc;
    word_t d;
    word_t last;
    e0 = errors;
    wait_empty(1'b0, "drain_underflow");
    repeat (4) @(posedge rd_clk);
    while (model_q.size() > 0) begin
      read_word(acc, d);
      check_val("drain_underflow", 1, acc);
      check_val("drain_underflow", model_q.pop_front(), d);
      check_val("drain_underflow", model_q.size() <= `FIFO_AEMPTY, aempty);
    end
    check_val("drain_underflow", 1, empty);
    last = rd_data;
    read_word(acc, d);
    check_val("drain_underflow", 0, acc);
    check_val("drain_underflow", last, d);
    end_test("drain_underflow", e0);
  endtask

  task automatic stream_writer();
    logic [31:0] s;
    int          n;
    s = SEED;
    n = 0;
    for (int cyc = 0; cyc < 4000 && n < WORDS; cyc++) begin
      @(posedge wr_clk);
      if (wr_en && !full) begin
        model_q.push_back(wr_data);
        n++;
      end
      s = lcg_next(s);
      wr_en   <= (n < WORDS) && (s[17:16] != 2'b00);
      wr_data <= s[31:24];
    end
    if (n < WORDS) begin
      $display("stream: writer timed out after %0d words", n);
      errors++;
    end
  endtask

  task automatic stream_reader();
    logic [31:0] s;
    logic        pend;
    int          n;
    s    = ~SEED;
    pend = 1'b0;
    n    = 0;
    for (int cyc = 0; cyc < 6000 && n < WORDS; cyc++) begin
      @(posedge rd_clk);
      if (pend && model_q.size() == 0) begin
        $display("stream: a word was read that was never written");
        errors++;
      end else if (pend) begin
        check_val("stream", model_q.pop_front(), rd_data);
      end
      n    = n + pend;
      pend = rd_en && !empty;
      s    = lcg_next(s);
      rd_en <= (n + pend < WORDS) && s[20];
    end
    if (n < WORDS) begin
      $display("stream: reader timed out after %0d words", n);
      errors++;
    end
  endtask

  task automatic test_stream();
    int e0;
    e0 = errors;
    fork
      stream_writer();
      stream_reader();
    join
    check_val("stream", 0, model_q.size());
    wait_empty(1'b1, "stream");
    end_test("stream", e0);
  endtask

  initial begin
    wr_rst_n = 1'b0;
    wr_en    = 1'b0;
    wr_data  = '0;
    rd_en    = 1'b0;
    repeat (16) @(posedge rd_clk);
    wr_rst_n <= 1'b1;
    repeat (3) @(posedge wr_clk);  // Both reset synchronizers release.
    test_reset();
    test_single();
    test_fill();
    test_drain();
    test_stream();
    $display("tests: %0d, passed: %0d, failed: %0d", tests_run,
             tests_run - tests_failed, tests_failed);
    if (errors == 0) begin
      $display("TEST PASSED");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule

/* filelist.f */
+incdir+verilog
verilog/fifo_pkg.sv
verilog/rst_sync.sv
verilog/ptr_sync.sv
verilog/dualport_ram_async.sv
verilog/fifo_wr_ptr.sv
verilog/fifo_rd_ptr.sv
verilog/async_fifo.sv
tb/async_fifo_tb.sv
